/* design/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // Machine information, read only
  localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID     = 12'hF11;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID       = 12'hF12;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID        = 12'hF13;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID       = 12'hF14;
  // Machine trap setup and handling
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS       = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MISA          = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEDELEG       = 12'h302;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIDELEG       = 12'h303;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIE           = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC         = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTINHIBIT = 12'h320;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH      = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC          = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE        = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL         = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIP           = 12'h344;
  // Machine counters
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE        = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET      = 12'hB02;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH       = 12'hB80;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH     = 12'hB82;
  // Supervisor
  localparam logic [CSR_ADDR_W-1:0] ADDR_SSTATUS       = 12'h100;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SIE           = 12'h104;
  localparam logic [CSR_ADDR_W-1:0] ADDR_STVEC         = 12'h105;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SSCRATCH      = 12'h140;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SEPC          = 12'h141;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SCAUSE        = 12'h142;
  localparam logic [CSR_ADDR_W-1:0] ADDR_STVAL         = 12'h143;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SIP           = 12'h144;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SATP          = 12'h180;
  // User counter mirrors
  localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE         = 12'hC00;
  localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET       = 12'hC02;
  localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH        = 12'hC80;
  localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH      = 12'hC82;

  localparam logic [XLEN-1:0] MSTATUS_RESET = 32'h0000_1800; // MPP = machine

  localparam logic [XLEN-1:0] MSTATUS_WMASK       = 32'h807F_F9EA;
  localparam logic [XLEN-1:0] SSTATUS_WMASK       = 32'h800D_E122; // Supervisor view only
  localparam logic [XLEN-1:0] MIE_WMASK           = 32'h0000_0AAA; // MEI SEI MTI STI MSI SSI
  localparam logic [XLEN-1:0] SIE_WMASK           = 32'h0000_0222;
  localparam logic [XLEN-1:0] MIP_WMASK           = 32'h0000_0002; // SSIP only
  localparam logic [XLEN-1:0] SIP_WMASK           = 32'h0000_0002;
  localparam logic [XLEN-1:0] MCOUNTINHIBIT_WMASK = 32'h0000_0005; // CY and IR

  // Masked bits take new data, the rest keep the old value
  function automatic logic [XLEN-1:0] masked_write(input logic [XLEN-1:0] old_val,
                                                   input logic [XLEN-1:0] new_val,
                                                   input logic [XLEN-1:0] mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_t;

  typedef struct packed {
    logic                  en;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } csr_wr_t;

  // One strobe per writable register
  typedef struct packed {
    logic mstatus;
    logic medeleg;
    logic mideleg;
    logic mie;
    logic mtvec;
    logic mcountinhibit;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mip;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
    logic sstatus;
    logic sie;
    logic stvec;
    logic sscratch;
    logic sepc;
    logic scause;
    logic stval;
    logic sip;
    logic satp;
  } csr_wsel_t;

  typedef struct packed {
    logic       sd;
    logic [7:0] rsvd_30_23;
    logic       tsr;
    logic       tw;
    logic       tvm;
    logic       mxr;
    logic       sum;
    logic       mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    logic [1:0] mpp;
    logic [1:0] rsvd_10_9;
    logic       spp;
    logic       mpie;
    logic       ube;
    logic       spie;
    logic       rsvd_4;
    logic       mie;
    logic       rsvd_2;
    logic       sie;
    logic       rsvd_0;
  } mstatus_fields_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    mstatus_fields_t f;
  } status_word_u;

  typedef struct packed {
    logic mxr;
    logic sum;
    logic tvm;
    logic tw;
    logic tsr;
  } mmu_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] stvec;
    logic [XLEN-1:0] sepc;
    logic [XLEN-1:0] scause;
    logic [XLEN-1:0] stval;
    logic [XLEN-1:0] satp;
  } trap_csrs_t;

  typedef struct packed {
    logic [XLEN-1:0] mcountinhibit;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] mcycleh;
    logic [XLEN-1:0] minstret;
    logic [XLEN-1:0] minstreth;
    logic [XLEN-1:0] cycle;
    logic [XLEN-1:0] cycleh;
    logic [XLEN-1:0] instret;
    logic [XLEN-1:0] instreth;
  } cnt_regs_t;

  typedef struct packed {
    status_word_u    mstatus;
    logic [XLEN-1:0] sstatus;
    trap_csrs_t      trap;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] sscratch;
    logic [XLEN-1:0] medeleg;
    logic [XLEN-1:0] mideleg;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] sie;
    logic [XLEN-1:0] sip;
    cnt_regs_t       counters;
  } csr_rdback_t;

endpackage

`default_nettype wire

/* design/csr_access_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_access_ctrl #(
  parameter logic [csr_pkg::XLEN-1:0] VENDOR_ID  = '0,
  parameter logic [csr_pkg::XLEN-1:0] ARCH_ID    = '0,
  parameter logic [csr_pkg::XLEN-1:0] IMPL_ID    = '0,
  parameter logic [csr_pkg::XLEN-1:0] HART_ID    = '0,
  parameter logic [csr_pkg::XLEN-1:0] MISA_VALUE = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  csr_pkg::csr_wr_t              sw_wr,
  input  csr_pkg::csr_wr_t              trap_wr,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr,
  input  csr_pkg::csr_rdback_t          rdback,
  output csr_pkg::csr_wsel_t            wsel,
  output logic [csr_pkg::XLEN-1:0]      wdata,
  output logic [csr_pkg::XLEN-1:0]      rd_data,
  output logic                          rd_error
);
  import csr_pkg::*;

  csr_wr_t wr;
  logic    sw_sel;

  assign sw_sel = !trap_wr.en; // Trap port always wins
  assign wr     = trap_wr.en ? trap_wr : sw_wr;
  assign wdata  = wr.data;

  always_comb begin
    wsel = '0;
    if (wr.en) begin
      case (wr.addr)
        ADDR_MSTATUS:       wsel.mstatus = 1'b1;
        ADDR_MTVEC:         wsel.mtvec = 1'b1;
        ADDR_MSCRATCH:      wsel.mscratch = 1'b1;
        ADDR_MEPC:          wsel.mepc = 1'b1;
        ADDR_MCAUSE:        wsel.mcause = 1'b1;
        ADDR_MTVAL:         wsel.mtval = 1'b1;
        ADDR_MIP:           wsel.mip = 1'b1;
        ADDR_SSTATUS:       wsel.sstatus = 1'b1;
        ADDR_STVEC:         wsel.stvec = 1'b1;
        ADDR_SSCRATCH:      wsel.sscratch = 1'b1;
        ADDR_SEPC:          wsel.sepc = 1'b1;
        ADDR_SCAUSE:        wsel.scause = 1'b1;
        ADDR_STVAL:         wsel.stval = 1'b1;
        ADDR_SIP:           wsel.sip = 1'b1;
        ADDR_SATP:          wsel.satp = 1'b1;
        // Software side only
        ADDR_MEDELEG:       wsel.medeleg = sw_sel;
        ADDR_MIDELEG:       wsel.mideleg = sw_sel;
        ADDR_MIE:           wsel.mie = sw_sel;
        ADDR_SIE:           wsel.sie = sw_sel;
        ADDR_MCOUNTINHIBIT: wsel.mcountinhibit = sw_sel;
        ADDR_MCYCLE:        wsel.mcycle = sw_sel;
        ADDR_MCYCLEH:       wsel.mcycleh = sw_sel;
        ADDR_MINSTRET:      wsel.minstret = sw_sel;
        ADDR_MINSTRETH:     wsel.minstreth = sw_sel;
        default:            wsel = '0; // Read-only or unknown
      endcase
    end
  end

  always_comb begin
    rd_data  = '0;
    rd_error = 1'b0;
    case (rd_addr)
      ADDR_MVENDORID:     rd_data = VENDOR_ID;
      ADDR_MARCHID:       rd_data = ARCH_ID;
      ADDR_MIMPID:        rd_data = IMPL_ID;
      ADDR_MHARTID:       rd_data = HART_ID;
      ADDR_MISA:          rd_data = MISA_VALUE;
      ADDR_MSTATUS:       rd_data = rdback.mstatus.raw;
      ADDR_MEDELEG:       rd_data = rdback.medeleg;
      ADDR_MIDELEG:       rd_data = rdback.mideleg;
      ADDR_MIE:           rd_data = rdback.mie;
      ADDR_MTVEC:         rd_data = rdback.trap.mtvec;
      ADDR_MCOUNTINHIBIT: rd_data = rdback.counters.mcountinhibit;
      ADDR_MSCRATCH:      rd_data = rdback.mscratch;
      ADDR_MEPC:          rd_data = rdback.trap.mepc;
      ADDR_MCAUSE:        rd_data = rdback.trap.mcause;
      ADDR_MTVAL:         rd_data = rdback.trap.mtval;
      ADDR_MIP:           rd_data = rdback.mip;
      ADDR_MCYCLE:        rd_data = rdback.counters.mcycle;
      ADDR_MCYCLEH:       rd_data = rdback.counters.mcycleh;
      ADDR_MINSTRET:      rd_data = rdback.counters.minstret;
      ADDR_MINSTRETH:     rd_data = rdback.counters.minstreth;
      ADDR_SSTATUS:       rd_data = rdback.sstatus;
      ADDR_SIE:           rd_data = rdback.sie;
      ADDR_STVEC:         rd_data = rdback.trap.stvec;
      ADDR_SSCRATCH:      rd_data = rdback.sscratch;
      ADDR_SEPC:          rd_data = rdback.trap.sepc;
      ADDR_SCAUSE:        rd_data = rdback.trap.scause;
      ADDR_STVAL:         rd_data = rdback.trap.stval;
      ADDR_SIP:           rd_data = rdback.sip;
      ADDR_SATP:          rd_data = rdback.trap.satp;
      ADDR_CYCLE:         rd_data = rdback.counters.cycle;
      ADDR_CYCLEH:        rd_data = rdback.counters.cycleh;
      ADDR_INSTRET:       rd_data = rdback.counters.instret;
      ADDR_INSTRETH:      rd_data = rdback.counters.instreth;
      default:            rd_error = 1'b1; // PMP, time and unused land here
    endcase
  end

  // Datapath modules rely on a single register per edge
  a_wsel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(wsel));

endmodule

`default_nettype wire

/* design/csr_status_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_status_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_wsel_t       wsel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  output csr_pkg::status_word_u    mstatus,
  output logic [csr_pkg::XLEN-1:0] sstatus,
  output csr_pkg::priv_t           privilege,
  output csr_pkg::mmu_ctrl_t       mmu
);
  import csr_pkg::*;

  status_word_u wr_word;

  assign wr_word.raw = wdata; // Field view of incoming data

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus.raw <= MSTATUS_RESET;
      sstatus     <= '0;
      privilege   <= PRIV_M;
    end else begin
      if (wsel.mstatus) begin
        mstatus.raw <= masked_write(mstatus.raw, wdata, MSTATUS_WMASK);
        privilege   <= priv_t'(wr_word.f.mpp); // Follows MPP of each write
      end
      if (wsel.sstatus)
        sstatus <= masked_write(sstatus, wdata, SSTATUS_WMASK);
    end
  end

  // MMU controls straight from the status fields
  assign mmu.mxr = mstatus.f.mxr;
  assign mmu.sum = mstatus.f.sum;
  assign mmu.tvm = mstatus.f.tvm;
  assign mmu.tw  = mstatus.f.tw;
  assign mmu.tsr = mstatus.f.tsr;

  a_mstatus_rsvd: assert property (@(posedge clk) disable iff (rst)
    (mstatus.raw & ~MSTATUS_WMASK) == '0);

endmodule

`default_nettype wire

/* design/csr_trap_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_trap_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_wsel_t       wsel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  output csr_pkg::trap_csrs_t      trap,
  output logic [csr_pkg::XLEN-1:0] mscratch,
  output logic [csr_pkg::XLEN-1:0] sscratch,
  output logic [csr_pkg::XLEN-1:0] medeleg,
  output logic [csr_pkg::XLEN-1:0] mideleg
);

  // Full-width registers, each loaded on its own strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      trap     <= '0;
      mscratch <= '0;
      sscratch <= '0;
      medeleg  <= '0;
      mideleg  <= '0;
    end else begin
      // Machine trap state
      if (wsel.mtvec)
        trap.mtvec <= wdata;
      if (wsel.mepc)
        trap.mepc <= wdata;
      if (wsel.mcause)
        trap.mcause <= wdata;
      if (wsel.mtval)
        trap.mtval <= wdata;
      if (wsel.mscratch)
        mscratch <= wdata;
      if (wsel.medeleg)
        medeleg <= wdata;
      if (wsel.mideleg)
        mideleg <= wdata;
      // Supervisor trap state
      if (wsel.stvec)
        trap.stvec <= wdata;
      if (wsel.sepc)
        trap.sepc <= wdata;
      if (wsel.scause)
        trap.scause <= wdata;
      if (wsel.stval)
        trap.stval <= wdata;
      if (wsel.sscratch)
        sscratch <= wdata;
      if (wsel.satp)
        trap.satp <= wdata; // Sv32 uses all 32 bits
    end
  end

endmodule

`default_nettype wire

/* design/csr_intr_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_intr_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_wsel_t       wsel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  output logic [csr_pkg::XLEN-1:0] mie,
  output logic [csr_pkg::XLEN-1:0] mip,
  output logic [csr_pkg::XLEN-1:0] sie,
  output logic [csr_pkg::XLEN-1:0] sip
);
  import csr_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      mie <= '0;
      mip <= '0;
      sie <= '0;
      sip <= '0;
    end else begin
      if (wsel.mie)
        mie <= masked_write(mie, wdata, MIE_WMASK);
      if (wsel.sie)
        sie <= masked_write(sie, wdata, SIE_WMASK); // Delegated sources only
      // Pending bits other than SSIP come from the interrupt sources
      if (wsel.mip)
        mip <= masked_write(mip, wdata, MIP_WMASK);
      if (wsel.sip)
        sip <= masked_write(sip, wdata, SIP_WMASK);
    end
  end

endmodule

`default_nettype wire

/* design/csr_counters.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_counters (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_pkg::csr_wsel_t       wsel,
  input  logic [csr_pkg::XLEN-1:0] wdata,
  output csr_pkg::cnt_regs_t       counters
);
  import csr_pkg::*;

  localparam int INH_CY = 0;
  localparam int INH_IR = 2;

  logic [2*XLEN-1:0] mcycle_q;
  logic [2*XLEN-1:0] minstret_q;
  logic [2*XLEN-1:0] cycle_q;
  logic [2*XLEN-1:0] instret_q;
  logic [XLEN-1:0]   inhibit_q;

  // A write to either half beats the increment
  function automatic logic [2*XLEN-1:0] count_next(input logic [2*XLEN-1:0] cur,
                                                   input logic wr_lo,
                                                   input logic wr_hi,
                                                   input logic inhibit,
                                                   input logic [XLEN-1:0] d);
    logic [2*XLEN-1:0] nxt;
    nxt = cur;
    if (wr_lo)
      nxt[XLEN-1:0] = d;
    else if (wr_hi)
      nxt[2*XLEN-1:XLEN] = d;
    else if (!inhibit)
      nxt = cur + 1'b1; // Carry runs into the upper half
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      cycle_q    <= '0;
      instret_q  <= '0;
      inhibit_q  <= '0;
    end else begin
      mcycle_q   <= count_next(mcycle_q, wsel.mcycle, wsel.mcycleh, inhibit_q[INH_CY], wdata);
      minstret_q <= count_next(minstret_q, wsel.minstret, wsel.minstreth,
                               inhibit_q[INH_IR], wdata);
      cycle_q    <= mcycle_q;   // User mirrors, one cycle behind
      instret_q  <= minstret_q;
      if (wsel.mcountinhibit)
        inhibit_q <= masked_write(inhibit_q, wdata, MCOUNTINHIBIT_WMASK);
    end
  end

  assign counters.mcountinhibit = inhibit_q;
  assign counters.mcycle        = mcycle_q[XLEN-1:0];
  assign counters.mcycleh       = mcycle_q[2*XLEN-1:XLEN];
  assign counters.minstret      = minstret_q[XLEN-1:0];
  assign counters.minstreth     = minstret_q[2*XLEN-1:XLEN];
  assign counters.cycle         = cycle_q[XLEN-1:0];
  assign counters.cycleh        = cycle_q[2*XLEN-1:XLEN];
  assign counters.instret       = instret_q[XLEN-1:0];
  assign counters.instreth      = instret_q[2*XLEN-1:XLEN];

  a_cycle_hold: assert property (@(posedge clk) disable iff (rst)
    inhibit_q[INH_CY] && !wsel.mcycle && !wsel.mcycleh |=> $stable(mcycle_q));

  a_instret_hold: assert property (@(posedge clk) disable iff (rst)
    inhibit_q[INH_IR] && !wsel.minstret && !wsel.minstreth |=> $stable(minstret_q));

endmodule

`default_nettype wire

/* design/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
  parameter logic [csr_pkg::XLEN-1:0] VENDOR_ID  = 32'h0004_4198,
  parameter logic [csr_pkg::XLEN-1:0] ARCH_ID    = 32'h0000_0001,
  parameter logic [csr_pkg::XLEN-1:0] IMPL_ID    = 32'h0000_0002,
  parameter logic [csr_pkg::XLEN-1:0] HART_ID    = 32'h0000_0000,
  parameter logic [csr_pkg::XLEN-1:0] MISA_VALUE = 32'h4000_1101  // RV32IMA
) (
  input  logic                           clk,
  input  logic                           rst,
  input  csr_pkg::csr_wr_t               sw_wr,
  input  csr_pkg::csr_wr_t               trap_wr,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr,
  output logic [csr_pkg::XLEN-1:0]       rd_data,
  output logic                           rd_error,
  output csr_pkg::status_word_u          mstatus,
  output csr_pkg::priv_t                 privilege,
  output csr_pkg::mmu_ctrl_t             mmu,
  output csr_pkg::trap_csrs_t            trap,
  output logic [csr_pkg::XLEN-1:0]       mie,
  output logic [csr_pkg::XLEN-1:0]       mip
);
  import csr_pkg::*;

  csr_wsel_t        wsel;
  logic [XLEN-1:0]  wdata;
  wire csr_rdback_t rdback; // Each datapath block drives its own slice

  csr_access_ctrl #(
    .VENDOR_ID  (VENDOR_ID),
    .ARCH_ID    (ARCH_ID),
    .IMPL_ID    (IMPL_ID),
    .HART_ID    (HART_ID),
    .MISA_VALUE (MISA_VALUE)
  ) csr_access_ctrl_inst (
    .clk      (clk),
    .rst      (rst),
    .sw_wr    (sw_wr),
    .trap_wr  (trap_wr),
    .rd_addr  (rd_addr),
    .rdback   (rdback),
    .wsel     (wsel),
    .wdata    (wdata),
    .rd_data  (rd_data),
    .rd_error (rd_error)
  );

  csr_status_regs csr_status_regs_inst (
    .clk       (clk),
    .rst       (rst),
    .wsel      (wsel),
    .wdata     (wdata),
    .mstatus   (rdback.mstatus),
    .sstatus   (rdback.sstatus),
    .privilege (privilege),
    .mmu       (mmu)
  );

  csr_trap_regs csr_trap_regs_inst (
    .clk      (clk),
    .rst      (rst),
    .wsel     (wsel),
    .wdata    (wdata),
    .trap     (rdback.trap),
    .mscratch (rdback.mscratch),
    .sscratch (rdback.sscratch),
    .medeleg  (rdback.medeleg),
    .mideleg  (rdback.mideleg)
  );

  csr_intr_regs csr_intr_regs_inst (
    .clk   (clk),
    .rst   (rst),
    .wsel  (wsel),
    .wdata (wdata),
    .mie   (rdback.mie),
    .mip   (rdback.mip),
    .sie   (rdback.sie),
    .sip   (rdback.sip)
  );

  csr_counters csr_counters_inst (
    .clk      (clk),
    .rst      (rst),
    .wsel     (wsel),
    .wdata    (wdata),
    .counters (rdback.counters)
  );

  // Register views for the core
  assign mstatus = rdback.mstatus;
  assign trap    = rdback.trap;
  assign mie     = rdback.mie;
  assign mip     = rdback.mip;

endmodule

`default_nettype wire

/* verif/csr_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_checker #(
  parameter int NAME_W = 192
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           chk_valid,
  input  logic                           chk_side,
  input  logic [csr_pkg::XLEN-1:0]       chk_data,
  input  logic                           chk_error,
  input  logic [NAME_W-1:0]              chk_name,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr,
  input  logic [csr_pkg::XLEN-1:0]       rd_data,
  input  logic                           rd_error,
  input  csr_pkg::status_word_u          mstatus,
  input  csr_pkg::priv_t                 privilege,
  input  csr_pkg::mmu_ctrl_t             mmu,
  input  csr_pkg::trap_csrs_t            trap,
  input  logic [csr_pkg::XLEN-1:0]       mie,
  input  logic [csr_pkg::XLEN-1:0]       mip,
  output int                             check_count,
  output int                             error_count
);
  import csr_pkg::*;

  logic [XLEN-1:0] side_word;
  logic [XLEN-1:0] out_word;
  logic            out_hit;

  assign side_word = {{(XLEN-7){1'b0}}, privilege, mmu}; // Privilege above mxr sum tvm tw tsr

  // Register outputs of the DUT that mirror the address being read
  always_comb begin
    out_hit  = 1'b1;
    out_word = '0;
    case (rd_addr)
      12'h300: out_word = mstatus.raw;
      12'h304: out_word = mie;
      12'h344: out_word = mip;
      12'h305: out_word = trap.mtvec;
      12'h341: out_word = trap.mepc;
      12'h342: out_word = trap.mcause;
      12'h343: out_word = trap.mtval;
      12'h105: out_word = trap.stvec;
      12'h141: out_word = trap.sepc;
      12'h142: out_word = trap.scause;
      12'h143: out_word = trap.stval;
      12'h180: out_word = trap.satp;
      default: out_hit = 1'b0; // No output port for this one
    endcase
  end

  initial begin
    check_count = 0;
    error_count = 0;
  end

  // Expectation was set on the previous edge, so the port is settled here
  always @(posedge clk) begin : compare
    int errs;
    errs = 0;
    if (!rst && chk_valid) begin
      if (chk_side) begin
        if (side_word !== chk_data) begin
          $display("FAIL %0s: privilege and mmu expected %h actual %h",
                   chk_name, chk_data, side_word);
          errs++;
        end
      end else begin
        if (rd_data !== chk_data) begin
          $display("FAIL %0s: rd_data expected %h actual %h", chk_name, chk_data, rd_data);
          errs++;
        end
        if (rd_error !== chk_error) begin
          $display("FAIL %0s: rd_error expected %b actual %b", chk_name, chk_error, rd_error);
          errs++;
        end
        if (out_hit && out_word !== chk_data) begin
          $display("FAIL %0s: register output expected %h actual %h",
                   chk_name, chk_data, out_word);
          errs++;
        end
      end
      check_count <= check_count + 1;
      error_count <= error_count + errs;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_csr_file;
  import csr_pkg::*;

  localparam int NAME_W      = 8 * 24;
  localparam int MAX_ENTRIES = 256;
  localparam int DRAIN_LIMIT = 16;

  logic                  clk;
  logic                  rst;
  csr_wr_t               sw_wr;
  csr_wr_t               trap_wr;
  logic [CSR_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_data;
  logic                  rd_error;
  status_word_u          mstatus;
  priv_t                 privilege;
  mmu_ctrl_t             mmu;
  trap_csrs_t            trap;
  logic [XLEN-1:0]       mie;
  logic [XLEN-1:0]       mip;

  // Expectation handed to the checker
  logic              chk_valid;
  logic              chk_side;
  logic [XLEN-1:0]   chk_data;
  logic              chk_error;
  logic [NAME_W-1:0] chk_name;
  int                check_count;
  int                error_count;

  int                    fd;
  int                    n;
  int                    entry_count;
  int                    issued;
  int                    tb_errors;
  int                    drain_cycles;
  int unsigned           seed;
  logic                  done;
  logic [NAME_W-1:0]     tok;
  logic [8*256-1:0]      rest;
  logic [3:0]            op;
  logic [CSR_ADDR_W-1:0] addr;
  logic [XLEN-1:0]       data;
  logic [XLEN-1:0]       exp_data;
  logic                  exp_err;

  csr_file csr_file_inst (
    .clk       (clk),
    .rst       (rst),
    .sw_wr     (sw_wr),
    .trap_wr   (trap_wr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_error  (rd_error),
    .mstatus   (mstatus),
    .privilege (privilege),
    .mmu       (mmu),
    .trap      (trap),
    .mie       (mie),
    .mip       (mip)
  );

  csr_checker #(
    .NAME_W (NAME_W)
  ) csr_checker_inst (
    .clk         (clk),
    .rst         (rst),
    .chk_valid   (chk_valid),
    .chk_side    (chk_side),
    .chk_data    (chk_data),
    .chk_error   (chk_error),
    .chk_name    (chk_name),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_error    (rd_error),
    .mstatus     (mstatus),
    .privilege   (privilege),
    .mmu         (mmu),
    .trap        (trap),
    .mie         (mie),
    .mip         (mip),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // One vector per rising edge, ports idle unless the op drives them
  task automatic apply_vector(input logic [NAME_W-1:0]     name,
                              input logic [3:0]            vop,
                              input logic [CSR_ADDR_W-1:0] vaddr,
                              input logic [XLEN-1:0]       vdata,
                              input logic [XLEN-1:0]       vexp,
                              input logic                  verr);
    logic [XLEN-1:0] filler;
    filler = $urandom();
    @(posedge clk);
    sw_wr     <= '0;
    trap_wr   <= '0;
    chk_valid <= 1'b0;
    case (vop)
      4'h1: sw_wr <= {1'b1, vaddr, vdata};
      4'h2: trap_wr <= {1'b1, vaddr, vdata};
      4'h3: begin
        trap_wr <= {1'b1, vaddr, vdata};
        sw_wr   <= {1'b1, vaddr, vdata ^ (filler | 32'h1)}; // Always differs from trap data
      end
      4'h4: sw_wr <= {1'b1, vaddr, filler};
      4'h5: trap_wr <= {1'b1, vaddr, filler};
      4'h6, 4'h7: begin
        rd_addr   <= vaddr;
        chk_valid <= 1'b1;
        chk_side  <= (vop == 4'h7);
        chk_data  <= vexp;
        chk_error <= verr;
        chk_name  <= name;
        issued++;
      end
      default: ; // Idle cycle
    endcase
  endtask

  initial begin
    seed      = $urandom(32'h9aee);
    rst       = 1'b1;
    sw_wr     = '0;
    trap_wr   = '0;
    rd_addr   = '0;
    chk_valid = 1'b0;
    chk_side  = 1'b0;
    chk_data  = '0;
    chk_error = 1'b0;
    chk_name  = '0;
    issued    = 0;
    tb_errors = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    fd = $fopen("verif/csr_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open verif/csr_vectors.txt");
      tb_errors++;
    end else begin
      done        = 1'b0;
      entry_count = 0;
      while (!done && entry_count < MAX_ENTRIES) begin
        entry_count++;
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1'b1; // End of file
        end else if (tok == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h", op, addr, data, exp_data, exp_err);
          if (n != 5) begin
            $display("ERROR: vector %0s has only %0d of its 5 fields", tok, n);
            tb_errors++;
            done = 1'b1;
          end else begin
            apply_vector(tok, op, addr, data, exp_data, exp_err);
          end
        end
      end
      $fclose(fd);
      if (!done) begin
        $display("ERROR: vector file has more than %0d entries", MAX_ENTRIES);
        tb_errors++;
      end
    end
    apply_vector("idle_end", 4'h0, '0, '0, '0, 1'b0);

    // Let the checker catch up with the last read
    drain_cycles = 0;
    while (check_count != issued && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      drain_cycles++;
    end
    if (check_count != issued) begin
      $display("ERROR: checker finished %0d of %0d checks before timing out",
               check_count, issued);
      tb_errors++;
    end
    if (issued == 0) begin
      $display("ERROR: no checks were issued from the vector file");
      tb_errors++;
    end

    $display("Checks run: %0d, mismatches: %0d, other errors: %0d",
             check_count, error_count, tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/csr_vectors.txt */
# Columns: name op addr data expected_data expected_error (all but name in hex)
# Ops: 0 idle, 1 sw write, 2 trap write, 3 trap and sw write, 4 sw filler, 5 trap filler
# Ops: 6 read port check, 7 check of {privilege, mxr sum tvm tw tsr} against expected_data
# After reset: mstatus 300, misa 301, vendor F11, arch F12, impl F13, hart F14
rst_mstatus         6 300 00000000 00001800 0
rst_priv_mmu        7 000 00000000 00000060 0
rst_mvendorid       6 F11 00000000 00044198 0
rst_marchid         6 F12 00000000 00000001 0
rst_mimpid          6 F13 00000000 00000002 0
rst_mhartid         6 F14 00000000 00000000 0
rst_misa            6 301 00000000 40001101 0
# Masked writes: sstatus 100, mie 304, sie 104, mip 344, sip 144
wr_mstatus_ones     1 300 FFFFFFFF 00000000 0
rd_mstatus_mask     6 300 00000000 807FF9EA 0
mmu_all_set         7 000 00000000 0000007F 0
wr_sstatus_ones     1 100 FFFFFFFF 00000000 0
rd_sstatus_mask     6 100 00000000 800DE122 0
wr_mie_ones         1 304 FFFFFFFF 00000000 0
rd_mie_mask         6 304 00000000 00000AAA 0
wr_sie_ones         1 104 FFFFFFFF 00000000 0
rd_sie_mask         6 104 00000000 00000222 0
wr_mip_ones         1 344 FFFFFFFF 00000000 0
rd_mip_mask         6 344 00000000 00000002 0
wr_sip_ones         1 144 FFFFFFFF 00000000 0
rd_sip_mask         6 144 00000000 00000002 0
wr_mstatus_mpp_s    1 300 00000800 00000000 0
rd_mstatus_mpp_s    6 300 00000000 00000800 0
priv_super          7 000 00000000 00000020 0
wr_mstatus_mxr_tsr  1 300 00480000 00000000 0
mmu_mxr_tsr         7 000 00000000 00000011 0
# Arbitration: mepc 341, mtvec 305
trap_wr_mtvec       2 305 80000100 00000000 0
rd_mtvec            6 305 00000000 80000100 0
both_wr_mepc        3 341 CAFE0010 00000000 0
rd_mepc_trap_wins   6 341 00000000 CAFE0010 0
trap_wr_mie         5 304 00000000 00000000 0
rd_mie_unchanged    6 304 00000000 00000AAA 0
sw_wr_mvendorid     4 F11 00000000 00000000 0
rd_mvendorid_kept   6 F11 00000000 00044198 0
# Read errors: pmpcfg0 3A0, pmpaddr0 3B0, time C01, unused 7FF
rd_pmpcfg0          6 3A0 00000000 00000000 1
rd_pmpaddr0         6 3B0 00000000 00000000 1
rd_time             6 C01 00000000 00000000 1
rd_unused           6 7FF 00000000 00000000 1
# Counters: mcountinhibit 320, mcycle B00, mcycleh B80, cycle C00, cycleh C80
wr_inhibit_set      1 320 00000005 00000000 0
rd_inhibit          6 320 00000000 00000005 0
wr_mcycle           1 B00 12345678 00000000 0
wr_mcycleh          1 B80 000000AB 00000000 0
rd_mcycle_held      6 B00 00000000 12345678 0
rd_mcycleh_held     6 B80 00000000 000000AB 0
wr_mcycleh_zero     1 B80 00000000 00000000 0
wr_mcycle_ones      1 B00 FFFFFFFF 00000000 0
wr_inhibit_clear    1 320 00000000 00000000 0
idle_one_edge       0 000 00000000 00000000 0
rd_mcycleh_carry    6 B80 00000000 00000001 0
rd_mcycle_run       6 B00 00000000 00000001 0
rd_cycle_mirror     6 C00 00000000 00000001 0
rd_cycleh_mirror    6 C80 00000000 00000001 0

/* filelist.f */
design/csr_pkg.sv
design/csr_access_ctrl.sv
design/csr_status_regs.sv
design/csr_trap_regs.sv
design/csr_intr_regs.sv
design/csr_counters.sv
design/csr_file.sv
verif/csr_checker.sv
verif/tb_csr_file.sv
